/* run.sh */
#!/usr/bin/env bash
# Build the pfpu testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pfpu -f src.f -o tb_pfpu \
	&& ./obj_dir/tb_pfpu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0

/* source/pfpu_addrgen.sv */
`timescale 1ns/1ns
// Mesh address generator of the pfpu.
// Raster scan of x then y over the mesh limits, a running linear
// vertex index, and the flag that marks the final vertex.
module pfpu_addrgen (
	input  logic                          sys_clk,
	input  logic                          sys_rst,
	input  logic                          start,
	input  logic                          vnext,
	input  logic [pfpu_pkg::mesh_w-1:0]   hmesh_last,
	input  logic [pfpu_pkg::mesh_w-1:0]   vmesh_last,
	output logic [pfpu_pkg::mesh_w-1:0]   x,
	output logic [pfpu_pkg::mesh_w-1:0]   y,
	output logic [pfpu_pkg::index_w-1:0]  index,
	output logic                          last
);
	logic step_d; // vnext delayed, the index follows one edge later.
	logic x_end;  // x is at the end of its row.

	assign x_end = x == hmesh_last;
	assign last  = x_end && (y == vmesh_last);

	always_ff @(posedge sys_clk) begin
		if (sys_rst || start) begin
			x      <= '0;
			y      <= '0;
			index  <= '0;
			step_d <= 1'b0;
		end else begin
			step_d <= vnext;
			if (step_d) index <= index + 1'b1;
			if (vnext) begin
				if (x_end) begin
					x <= '0;
					y <= (y == vmesh_last) ? '0 : y + 1'b1; // wraps to 0 after the run.
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

	// the scan stays inside the row limit set by the host.
	a_x_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
		x <= hmesh_last);

endmodule

/* source/pfpu_ctlif.sv */
`timescale 1ns/1ns
// CSR control interface of the pfpu.
// Address decode into control registers, register file and program memory,
// control registers, vertex and stray counters, irq on the falling edge
// of busy, and the registered one-hot read mux.
module pfpu_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic [13:0]                      csr_a,
	input  logic                             csr_we,
	input  logic [pfpu_pkg::data_w-1:0]      csr_di,
	output logic [pfpu_pkg::data_w-1:0]      csr_do,
	output logic                             irq,
	output logic                             start,
	input  logic                             busy,
	output logic [pfpu_pkg::data_w-3:0]      dma_base,
	output logic [pfpu_pkg::mesh_w-1:0]      hmesh_last,
	output logic [pfpu_pkg::mesh_w-1:0]      vmesh_last,
	output logic [pfpu_pkg::reg_aw-1:0]      cr_addr,
	input  logic [pfpu_pkg::data_w-1:0]      cr_di,
	output logic [pfpu_pkg::data_w-1:0]      cr_do,
	output logic                             cr_w_en,
	output logic [1:0]                       cp_page,
	output logic [8:0]                       cp_offset,
	input  logic [pfpu_pkg::data_w-1:0]      cp_di,
	output logic [pfpu_pkg::data_w-1:0]      cp_do,
	output logic                             cp_w_en,
	input  logic                             vnext,
	input  logic                             err_stray,
	input  logic [pfpu_pkg::pending_w-1:0]   dma_pending,
	input  logic [pfpu_pkg::pc_w-1:0]        pc
);
	import pfpu_pkg::*;

	logic               sel;        // this block is addressed.
	logic               ctl_we;     // write to a control register.
	logic               busy_d;     // busy one cycle ago, for the irq edge.
	logic               sel_cont;   // read data comes from the control registers.
	logic               sel_regf;   // read data comes from the register file.
	logic               sel_prog;   // read data comes from program memory.
	logic [data_w-1:0]  ctl_do;     // registered control register readback.
	logic [index_w-1:0] vertex_cnt; // vertices completed since the last CTRL write.
	logic [index_w-1:0] stray_cnt;  // undefined opcodes executed.

	assign sel    = csr_a[13:10] == csr_addr;
	assign ctl_we = sel & csr_we & ~csr_a[9] & ~csr_a[8];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control registers and counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			busy_d     <= 1'b0;
			irq        <= 1'b0;
			start      <= 1'b0;
			sel_cont   <= 1'b0;
			sel_regf   <= 1'b0;
			sel_prog   <= 1'b0;
			dma_base   <= '0;
			hmesh_last <= '0;
			vmesh_last <= '0;
			cp_page    <= '0;
			vertex_cnt <= '0;
			stray_cnt  <= '0;
		end else begin
			busy_d <= busy;
			start  <= 1'b0;                                   // start is a single pulse.
			if (busy_d & ~busy) irq <= 1'b1;                  // run has just finished.
			if (vnext) vertex_cnt <= vertex_cnt + 1'b1;
			if (err_stray) stray_cnt <= stray_cnt + 1'b1;
			sel_cont <= sel & ~csr_a[9] & ~csr_a[8];          // the selects line up with
			sel_regf <= sel & ~csr_a[9] & csr_a[8];           // the synchronous memory
			sel_prog <= sel & csr_a[9];                       // read data next cycle.
			if (ctl_we) begin
				case (csr_reg_t'(csr_a[3:0]))
					CTRL: begin
						start      <= csr_di[0];              // bit 0 launches a run.
						irq        <= 1'b0;                   // any CTRL write acks irq.
						vertex_cnt <= '0;
						stray_cnt  <= '0;
					end
					BASE:    dma_base   <= csr_di[data_w-1:2];
					HMESH:   hmesh_last <= csr_di[mesh_w-1:0];
					VMESH:   vmesh_last <= csr_di[mesh_w-1:0];
					PAGE:    cp_page    <= csr_di[1:0];
					default: ;                                // counters are read only.
				endcase
			end
		end
	end

	// readback of the control registers, sampled with the address.
	always_ff @(posedge sys_clk) begin
		case (csr_reg_t'(csr_a[3:0]))
			CTRL:     ctl_do <= data_w'({irq, busy});
			BASE:     ctl_do <= {dma_base, 2'b00};
			HMESH:    ctl_do <= data_w'(hmesh_last);
			VMESH:    ctl_do <= data_w'(vmesh_last);
			PAGE:     ctl_do <= data_w'(cp_page);
			VERTICES: ctl_do <= data_w'(vertex_cnt);
			STRAYS:   ctl_do <= data_w'(stray_cnt);
			PENDING:  ctl_do <= data_w'(dma_pending);
			PC:       ctl_do <= data_w'(pc);
			default:  ctl_do <= '0;
		endcase
	end

	assign csr_do = ({data_w{sel_cont}} & ctl_do)
		| ({data_w{sel_regf}} & cr_di)
		| ({data_w{sel_prog}} & cp_di); // zero when nothing was selected.

	assign cr_addr   = csr_a[reg_aw-1:0];
	assign cr_do     = csr_di;
	assign cr_w_en   = sel & csr_we & ~csr_a[9] & csr_a[8];
	assign cp_offset = csr_a[8:0];
	assign cp_do     = csr_di;
	assign cp_w_en   = sel & csr_we & csr_a[9];

	// irq is raised only once the DMA queue has drained.
	a_irq_drained: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(busy_d && !busy) |-> (dma_pending == '0));

endmodule

/* source/pfpu_dma.sv */
`timescale 1ns/1ns
// DMA write queue of the pfpu.
// Four-entry FIFO of result pairs, each stored with its write address
// formed from the DMA base and the vertex index, and a strobe/ack
// output port that presents the head entry.
module pfpu_dma (
	input  logic                            sys_clk,
	input  logic                            sys_rst,
	input  logic [pfpu_pkg::data_w-3:0]     dma_base,
	input  logic [pfpu_pkg::index_w-1:0]    index,
	input  logic                            push,
	input  logic [pfpu_pkg::data_w-1:0]     push_a,
	input  logic [pfpu_pkg::data_w-1:0]     push_b,
	input  logic                            dma_ack,
	output logic                            full,
	output logic [pfpu_pkg::pending_w-1:0]  dma_pending,
	output logic                            dma_stb,
	output logic [pfpu_pkg::data_w-3:0]     dma_adr,
	output logic [2*pfpu_pkg::data_w-1:0]   dma_dat
);
	import pfpu_pkg::*;

	logic [data_w-3:0]   adr_q [0:3]; // word address of each entry.
	logic [2*data_w-1:0] dat_q [0:3]; // result pair, a in the upper half.
	logic [1:0]          wr_ptr;
	logic [1:0]          rd_ptr;
	logic                wr;          // accepted push.
	logic                rd;          // head entry acknowledged.

	assign full    = dma_pending == pending_w'(4);
	assign dma_stb = dma_pending != '0;
	assign dma_adr = adr_q[rd_ptr];
	assign dma_dat = dat_q[rd_ptr];
	assign wr      = push & ~full;
	assign rd      = dma_stb & dma_ack;

	always_ff @(posedge sys_clk) begin
		if (wr) begin
			adr_q[wr_ptr] <= dma_base + (data_w-2)'({index, 1'b0}); // two words per vertex.
			dat_q[wr_ptr] <= {push_a, push_b};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			dma_pending <= '0;
		end else begin
			if (wr) wr_ptr <= wr_ptr + 1'b1;
			if (rd) rd_ptr <= rd_ptr + 1'b1;
			dma_pending <= dma_pending + pending_w'(wr) - pending_w'(rd);
		end
	end

	// an unacknowledged write is held steady for the external port.
	a_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		dma_stb && !dma_ack |=> dma_stb && $stable(dma_adr) && $stable(dma_dat));

endmodule

/* source/pfpu_pkg.sv */
// Shared definitions for the pfpu subsystem.
// Datapath, mesh, index and program counter widths,
// instruction word field positions, the opcode and
// sequencer state enums, and the CSR control register map.
package pfpu_pkg;

	localparam int data_w    = 32; // datapath and CSR word width.
	localparam int mesh_w    = 7;  // mesh limits and coordinates.
	localparam int index_w   = 14; // linear vertex index.
	localparam int pc_w      = 11; // 2-bit page above a 9-bit offset.
	localparam int reg_aw    = 7;  // 128 registers.
	localparam int pending_w = 3;  // DMA queue occupancy, 0 to 4.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction word fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int op_hi = 31; // opcode.
	localparam int op_lo = 27;
	localparam int a_hi  = 26; // operand a register.
	localparam int a_lo  = 20;
	localparam int b_hi  = 19; // operand b register.
	localparam int b_lo  = 13;
	localparam int d_hi  = 12; // destination register.
	localparam int d_lo  = 6;

	typedef enum logic [4:0] {
		OP_NOP = 5'd0, OP_ADD = 5'd1, OP_SUB = 5'd2, OP_AND = 5'd3, OP_OR = 5'd4,
		OP_XOR = 5'd5, OP_COPY = 5'd6, OP_VECTOUT = 5'd7, OP_END = 5'd8
	} opcode_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_FETCH, ST_READ, ST_EXEC, ST_WAIT_DMA
	} seq_state_t;

	typedef enum logic [3:0] {
		CTRL = 4'd0, BASE = 4'd1, HMESH = 4'd2, VMESH = 4'd3, PAGE = 4'd4,
		VERTICES = 4'd5, STRAYS = 4'd6, PENDING = 4'd7, PC = 4'd8
	} csr_reg_t;

endpackage

/* source/pfpu_prog.sv */
`timescale 1ns/1ns
// Program memory of the pfpu.
// 2048 words, with a CSR read/write port addressed by page and offset
// and a synchronous fetch port for the sequencer.
module pfpu_prog (
	input  logic                          sys_clk,
	input  logic [1:0]                    cp_page,
	input  logic [8:0]                    cp_offset,
	input  logic [pfpu_pkg::data_w-1:0]   cp_do,
	input  logic                          cp_w_en,
	output logic [pfpu_pkg::data_w-1:0]   cp_di,
	input  logic [pfpu_pkg::pc_w-1:0]     pc,
	output logic [pfpu_pkg::data_w-1:0]   instr
);
	import pfpu_pkg::*;

	logic [data_w-1:0] mem [0:(1<<pc_w)-1];
	logic [pc_w-1:0]   cp_addr; // CSR word address.

	assign cp_addr = {cp_page, cp_offset};

	always_ff @(posedge sys_clk) begin
		if (cp_w_en) mem[cp_addr] <= cp_do;
		cp_di <= mem[cp_addr]; // old data on a simultaneous write.
		instr <= mem[pc];
	end

endmodule

/* source/pfpu_regf.sv */
`timescale 1ns/1ns
// Register file of the pfpu.
// 128 words with a CSR port, two sequencer read ports and one
// sequencer write port. Registers 0 and 1 read as the x and y coordinates.
module pfpu_regf (
	input  logic                          sys_clk,
	input  logic [pfpu_pkg::reg_aw-1:0]   cr_addr,
	input  logic [pfpu_pkg::data_w-1:0]   cr_do,
	input  logic                          cr_w_en,
	output logic [pfpu_pkg::data_w-1:0]   cr_di,
	input  logic [pfpu_pkg::reg_aw-1:0]   ra_addr,
	input  logic [pfpu_pkg::reg_aw-1:0]   rb_addr,
	output logic [pfpu_pkg::data_w-1:0]   ra_data,
	output logic [pfpu_pkg::data_w-1:0]   rb_data,
	input  logic [pfpu_pkg::reg_aw-1:0]   w_addr,
	input  logic [pfpu_pkg::data_w-1:0]   w_data,
	input  logic                          w_en,
	input  logic [pfpu_pkg::mesh_w-1:0]   x,
	input  logic [pfpu_pkg::mesh_w-1:0]   y
);
	import pfpu_pkg::*;

	logic [data_w-1:0] mem [0:(1<<reg_aw)-1];
	logic              seq_wr; // sequencer write to a real register.
	logic              csr_wr; // CSR write that does not collide with it.

	// read of one port, with the coordinates mapped over registers 0 and 1.
	function automatic logic [data_w-1:0] rd(input logic [reg_aw-1:0] a);
		case (a)
			reg_aw'(0): return data_w'(x);
			reg_aw'(1): return data_w'(y);
			default:    return mem[a];
		endcase
	endfunction

	assign seq_wr = w_en && (w_addr > reg_aw'(1));
	assign csr_wr = cr_w_en && (cr_addr > reg_aw'(1))
		&& !(seq_wr && (w_addr == cr_addr)); // sequencer wins a same-address clash.

	always_ff @(posedge sys_clk) begin
		if (seq_wr) mem[w_addr] <= w_data;
		if (csr_wr) mem[cr_addr] <= cr_do;
		ra_data <= rd(ra_addr);
		rb_data <= rd(rb_addr);
		cr_di   <= rd(cr_addr);
	end

endmodule

/* source/pfpu_seq.sv */
`timescale 1ns/1ns
// Sequencer of the pfpu.
// Fetch, operand read and execute FSM over the selected program page,
// integer ALU with writeback, DMA push with stall on a full queue,
// vertex stepping at OP_END, and the busy level.
module pfpu_seq (
	input  logic                            sys_clk,
	input  logic                            sys_rst,
	input  logic                            start,
	input  logic [1:0]                      cp_page,
	input  logic [pfpu_pkg::data_w-1:0]     instr,
	input  logic [pfpu_pkg::data_w-1:0]     ra_data,
	input  logic [pfpu_pkg::data_w-1:0]     rb_data,
	input  logic                            full,
	input  logic                            last,
	input  logic [pfpu_pkg::pending_w-1:0]  dma_pending,
	output logic [pfpu_pkg::pc_w-1:0]       pc,
	output logic [pfpu_pkg::reg_aw-1:0]     ra_addr,
	output logic [pfpu_pkg::reg_aw-1:0]     rb_addr,
	output logic [pfpu_pkg::reg_aw-1:0]     w_addr,
	output logic [pfpu_pkg::data_w-1:0]     w_data,
	output logic                            w_en,
	output logic                            push,
	output logic [pfpu_pkg::data_w-1:0]     push_a,
	output logic [pfpu_pkg::data_w-1:0]     push_b,
	output logic                            vnext,
	output logic                            err_stray,
	output logic                            busy
);
	import pfpu_pkg::*;

	seq_state_t state;
	opcode_t    op;       // decoded opcode of the current instruction.
	logic       is_alu;   // opcode writes a result back.
	logic       is_stray; // opcode is undefined.
	logic       exec;     // instruction is in its execute cycle.

	assign op      = opcode_t'(instr[op_hi:op_lo]);
	assign ra_addr = instr[a_hi:a_lo]; // operands are read while in ST_READ.
	assign rb_addr = instr[b_hi:b_lo];
	assign w_addr  = instr[d_hi:d_lo];
	assign exec    = state == ST_EXEC;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode and ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		is_alu   = 1'b1;
		is_stray = 1'b0;
		w_data   = ra_data; // OP_COPY and the default.
		case (op)
			OP_ADD:  w_data = ra_data + rb_data;
			OP_SUB:  w_data = ra_data - rb_data;
			OP_AND:  w_data = ra_data & rb_data;
			OP_OR:   w_data = ra_data | rb_data;
			OP_XOR:  w_data = ra_data ^ rb_data;
			OP_COPY: w_data = ra_data;
			OP_NOP, OP_VECTOUT, OP_END: is_alu = 1'b0;
			default: begin
				is_alu   = 1'b0; // an undefined opcode behaves as OP_NOP.
				is_stray = 1'b1;
			end
		endcase
	end

	assign w_en      = exec && is_alu;
	assign vnext     = exec && (op == OP_END);
	assign err_stray = exec && is_stray;
	assign push      = (exec || (state == ST_WAIT_DMA)) && (op == OP_VECTOUT) && !full;
	assign push_a    = ra_data;
	assign push_b    = rb_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= ST_IDLE;
			pc    <= '0;
			busy  <= 1'b0;
		end else begin
			if (start) busy <= 1'b1;
			else if ((state == ST_IDLE) && (dma_pending == '0)) busy <= 1'b0; // queue drained.
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_FETCH;
						pc    <= {cp_page, 9'd0};
					end
				end
				ST_FETCH: state <= ST_READ;  // instr is valid next cycle.
				ST_READ:  state <= ST_EXEC;  // operands are valid next cycle.
				ST_EXEC, ST_WAIT_DMA: begin
					if (op == OP_END) begin
						pc    <= {pc[pc_w-1:9], 9'd0};
						state <= last ? ST_IDLE : ST_FETCH;
					end else if ((op == OP_VECTOUT) && full) begin
						state <= ST_WAIT_DMA; // hold until the queue has room.
					end else begin
						pc    <= {pc[pc_w-1:9], pc[8:0] + 9'd1}; // wraps inside the page.
						state <= ST_FETCH;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// the queue is never pushed beyond its four entries.
	a_push_not_full: assert property (@(posedge sys_clk) disable iff (sys_rst)
		push |-> (dma_pending != pending_w'(4)));

endmodule

/* source/pfpu_top.sv */
`timescale 1ns/1ns
// Top level of the pfpu subsystem.
// Control interface, register file, program memory, address generator,
// sequencer and DMA queue, wired together.
module pfpu_top #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic                            sys_clk,
	input  logic                            sys_rst,
	input  logic [13:0]                     csr_a,
	input  logic                            csr_we,
	input  logic [pfpu_pkg::data_w-1:0]     csr_di,
	output logic [pfpu_pkg::data_w-1:0]     csr_do,
	output logic                            irq,
	output logic                            dma_stb,
	output logic [pfpu_pkg::data_w-3:0]     dma_adr,
	output logic [2*pfpu_pkg::data_w-1:0]   dma_dat,
	input  logic                            dma_ack
);
	import pfpu_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control and mesh setup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic                 start;
	logic                 busy;
	logic                 vnext;
	logic                 err_stray;
	logic [data_w-3:0]    dma_base;
	logic [mesh_w-1:0]    hmesh_last;
	logic [mesh_w-1:0]    vmesh_last;
	logic [mesh_w-1:0]    x;
	logic [mesh_w-1:0]    y;
	logic [index_w-1:0]   index;
	logic                 last;

	// CSR ports of the memories.
	logic [reg_aw-1:0]    cr_addr;
	logic [data_w-1:0]    cr_do;
	logic [data_w-1:0]    cr_di;
	logic                 cr_w_en;
	logic [1:0]           cp_page;
	logic [8:0]           cp_offset;
	logic [data_w-1:0]    cp_do;
	logic [data_w-1:0]    cp_di;
	logic                 cp_w_en;

	// sequencer datapath and queue.
	logic [pc_w-1:0]      pc;
	logic [data_w-1:0]    instr;
	logic [reg_aw-1:0]    ra_addr;
	logic [reg_aw-1:0]    rb_addr;
	logic [data_w-1:0]    ra_data;
	logic [data_w-1:0]    rb_data;
	logic [reg_aw-1:0]    w_addr;
	logic [data_w-1:0]    w_data;
	logic                 w_en;
	logic                 push;
	logic [data_w-1:0]    push_a;
	logic [data_w-1:0]    push_b;
	logic                 full;
	logic [pending_w-1:0] dma_pending;

	pfpu_ctlif #(.csr_addr(csr_addr)) u_pfpu_ctlif (.*);
	pfpu_regf    u_pfpu_regf (.*);
	pfpu_prog    u_pfpu_prog (.*);
	pfpu_addrgen u_pfpu_addrgen (.*);
	pfpu_seq     u_pfpu_seq (.*);
	pfpu_dma     u_pfpu_dma (.*);

endmodule

/* src.f */
source/pfpu_pkg.sv
source/pfpu_ctlif.sv
source/pfpu_regf.sv
source/pfpu_prog.sv
source/pfpu_addrgen.sv
source/pfpu_seq.sv
source/pfpu_dma.sv
source/pfpu_top.sv
test/tb_pfpu.sv

/* test/tb_pfpu.sv */
`timescale 1ns/1ns
// Testbench of the pfpu subsystem.
// Clock and reset, an LFSR for random stimulus, CSR read and write tasks,
// a DMA responder with random acknowledge, a reference model of the
// sequencer, and five tests from register readback to stray opcodes.
module tb_pfpu;
	import pfpu_pkg::*;

	localparam logic [3:0]  blk        = 4'h0;         // CSR block address of the DUT.
	localparam logic [31:0] seed       = 32'hf6fc_2a87;
	localparam int          poll_limit = 4000;         // status reads before a run times out.

	logic        sys_clk;
	logic        sys_rst;
	logic [13:0] csr_a;
	logic        csr_we;
	logic [31:0] csr_di;
	logic        dma_ack;
	logic [31:0] csr_do;
	logic        irq;
	logic        dma_stb;
	logic [29:0] dma_adr;
	logic [63:0] dma_dat;

	logic [31:0] lfsr      = seed; // stimulus stream.
	logic [31:0] ack_state = seed; // acknowledge stream, kept apart from the stimulus.
	logic        ack_all;
	int          errors;
	int          tests_run;
	int          tests_failed;
	bit          abort;            // a run timed out and the later tests are skipped.
	bit          busy_seen;        // busy was read high right after start.
	logic [31:0] model_reg [0:127];
	logic [31:0] prog [$];         // program of the current run.
	logic [29:0] exp_adr [$];      // DMA writes the model expects, in raster order.
	logic [63:0] exp_dat [$];
	logic [29:0] want_adr;
	logic [63:0] want_dat;
	logic [6:0]  h_last;
	logic [6:0]  v_last;
	int          stray_exp;

	pfpu_top #(.csr_addr(blk)) u_pfpu_top (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .csr_a(csr_a), .csr_we(csr_we),
		.csr_di(csr_di), .csr_do(csr_do), .irq(irq), .dma_stb(dma_stb),
		.dma_adr(dma_adr), .dma_dat(dma_dat), .dma_ack(dma_ack)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random numbers and helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1.
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]}; // one step per bit taken.
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic [13:0] ctl_a(input csr_reg_t r);
		return {blk, 6'b0, r};
	endfunction

	function automatic logic [13:0] reg_a(input logic [6:0] r);
		return {blk, 3'b010, r};
	endfunction

	function automatic logic [13:0] prog_a(input logic [8:0] off);
		return {blk, 1'b1, off}; // page comes from the PAGE register.
	endfunction

	function automatic logic [31:0] encode(input logic [4:0] op, input logic [6:0] a,
		input logic [6:0] b, input logic [6:0] d);
		return {op, a, b, d, 6'd0};
	endfunction

	function automatic opcode_t alu_op(input int r);
		case (r % 6)
			0:       return OP_ADD;
			1:       return OP_SUB;
			2:       return OP_AND;
			3:       return OP_OR;
			4:       return OP_XOR;
			default: return OP_COPY;
		endcase
	endfunction

	task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_start);
			tests_failed++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CSR access
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic csr_write(input logic [13:0] a, input logic [31:0] d);
		@(posedge sys_clk);
		csr_a  <= a;
		csr_we <= 1'b1;
		csr_di <= d;
		@(posedge sys_clk); // the DUT takes the write on this edge.
		csr_we <= 1'b0;
	endtask

	task automatic csr_read(input logic [13:0] a, output logic [31:0] d);
		@(posedge sys_clk);
		csr_a  <= a;
		csr_we <= 1'b0;
		@(posedge sys_clk); // csr_do is valid one edge after the address.
		@(negedge sys_clk);
		d = csr_do;
	endtask

	task automatic expect_read(input string name, input logic [13:0] a, input logic [31:0] exp);
		logic [31:0] v;
		csr_read(a, v);
		check_hex(name, 64'(v), 64'(exp));
	endtask

	// the responder acks about one cycle in sixteen, so the queue backs up.
	always @(posedge sys_clk) begin
		ack_all = 1'b1;
		for (int i = 0; i < 4; i++) begin
			ack_all   = ack_all & ack_state[0];
			ack_state = lfsr_next(ack_state);
		end
		dma_ack <= ack_all;
	end

	// a write completes on the next edge when strobe and ack are both high here.
	always @(negedge sys_clk) begin
		if (!sys_rst && dma_stb && dma_ack) begin
			assert (exp_adr.size() != 0) else begin
				$display("DMA write to %h arrived when none was expected", dma_adr);
				errors++;
			end
			if (exp_adr.size() != 0) begin
				want_adr = exp_adr.pop_front();
				want_dat = exp_dat.pop_front();
				check_hex("dma_adr", 64'(dma_adr), 64'(want_adr));
				check_hex("dma_dat", dma_dat, want_dat);
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] model_rd(input logic [6:0] r, input logic [6:0] x,
		input logic [6:0] y);
		if (r == 7'd0) return 32'(x);
		if (r == 7'd1) return 32'(y);
		return model_reg[r];
	endfunction

	task automatic model_vertex(input logic [6:0] x, input logic [6:0] y, input int idx,
		input logic [29:0] base_w);
		logic [4:0]  opc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic        wr;
		foreach (prog[i]) begin
			opc = prog[i][31:27];
			a   = model_rd(prog[i][26:20], x, y);
			b   = model_rd(prog[i][19:13], x, y);
			res = a;
			wr  = 1'b1;
			case (opc)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_COPY: res = a;
				OP_VECTOUT: begin
					exp_adr.push_back(base_w + 30'(2 * idx)); // two words per vertex.
					exp_dat.push_back({a, b});
					wr = 1'b0;
				end
				default: wr = 1'b0; // nop, end and undefined opcodes write nothing.
			endcase
			if (wr && (prog[i][12:6] > 7'd1)) model_reg[prog[i][12:6]] = res;
		end
	endtask

	// sets up a random mesh and program, runs the model, then starts the DUT.
	task automatic run_mesh(input int n_stray);
		logic [31:0] base;
		logic [1:0]  page;
		int          n_alu;
		int          pos;
		int          idx;
		h_last = 7'(rand_bits(2));
		v_last = 7'(rand_bits(2));
		page   = 2'(rand_bits(2));
		base   = rand_bits(32);
		csr_write(ctl_a(BASE), base);
		csr_write(ctl_a(HMESH), 32'(h_last));
		csr_write(ctl_a(VMESH), 32'(v_last));
		csr_write(ctl_a(PAGE), 32'(page));
		for (int r = 2; r < 16; r++) begin
			model_reg[r] = rand_bits(32);
			csr_write(reg_a(7'(r)), model_reg[r]);
		end
		prog.delete();
		n_alu = 2 + int'(rand_bits(2));
		for (int k = 0; k < n_alu; k++) begin
			prog.push_back(encode(alu_op(int'(rand_bits(3))), 7'(rand_bits(4)),
				7'(rand_bits(4)), 7'(2 + rand_bits(4) % 14)));
		end
		prog.push_back(encode(OP_VECTOUT, 7'(rand_bits(4)), 7'(rand_bits(4)), 7'd0));
		for (int s = 0; s < n_stray; s++) begin
			pos = int'(rand_bits(3)) % (prog.size() + 1);
			prog.insert(pos, encode(5'(9 + rand_bits(5) % 23), 7'(rand_bits(7)),
				7'(rand_bits(7)), 7'(rand_bits(7))));
		end
		prog.push_back(encode(OP_END, 7'd0, 7'd0, 7'd0));
		foreach (prog[i]) csr_write(prog_a(9'(i)), prog[i]);
		exp_adr.delete();
		exp_dat.delete();
		idx = 0;
		for (int yy = 0; yy <= int'(v_last); yy++) begin
			for (int xx = 0; xx <= int'(h_last); xx++) begin
				model_vertex(7'(xx), 7'(yy), idx, base[31:2]);
				idx++;
			end
		end
		stray_exp = n_stray * idx;
		csr_write(ctl_a(CTRL), 32'h1);
	endtask

	task automatic wait_done();
		logic [31:0] v;
		int          n;
		csr_read(ctl_a(CTRL), v);
		busy_seen = v[0];
		n = 0;
		while (v[0] && (n < poll_limit)) begin
			csr_read(ctl_a(CTRL), v);
			n++;
		end
		assert (!v[0]) else begin
			$display("timeout: run still busy after %0d status reads", poll_limit);
			errors++;
			abort = 1'b1;
		end
	endtask

	task automatic check_drained();
		assert (exp_adr.size() == 0) else begin
			$display("%0d expected DMA writes never arrived", exp_adr.size());
			errors++;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_readback();
		logic [31:0] bv;
		logic [31:0] hv;
		logic [31:0] vv;
		logic [31:0] pv;
		int          e0;
		e0 = errors;
		bv = rand_bits(32);
		hv = rand_bits(32);
		vv = rand_bits(32);
		pv = rand_bits(32);
		csr_write(ctl_a(BASE), bv);
		csr_write(ctl_a(HMESH), hv);
		csr_write(ctl_a(VMESH), vv);
		csr_write(ctl_a(PAGE), pv);
		expect_read("csr_do BASE", ctl_a(BASE), bv & 32'hffff_fffc);
		expect_read("csr_do HMESH", ctl_a(HMESH), hv & 32'h7f);
		expect_read("csr_do VMESH", ctl_a(VMESH), vv & 32'h7f);
		expect_read("csr_do PAGE", ctl_a(PAGE), pv & 32'h3);
		expect_read("csr_do unselected", {blk ^ 4'h5, 10'd2}, 32'h0);
		report_test("1 control readback", e0);
	endtask

	task automatic test_memory();
		logic [31:0] pdat [0:1][0:15];
		logic [8:0]  poff [0:1][0:15];
		logic [1:0]  pg [0:1];
		int          e0;
		e0 = errors;
		for (int r = 2; r < 128; r++) begin
			model_reg[r] = rand_bits(32);
			csr_write(reg_a(7'(r)), model_reg[r]);
		end
		for (int r = 2; r < 128; r++) begin
			expect_read($sformatf("csr_do reg %0d", r), reg_a(7'(r)), model_reg[r]);
		end
		expect_read("csr_do reg 0", reg_a(7'd0), 32'h0); // x and y are zero while idle.
		expect_read("csr_do reg 1", reg_a(7'd1), 32'h0);
		pg[0] = 2'(rand_bits(2));
		pg[1] = pg[0] ^ 2'(1 + rand_bits(2) % 3);
		for (int p = 0; p < 2; p++) begin
			csr_write(ctl_a(PAGE), 32'(pg[p]));
			for (int k = 0; k < 16; k++) begin
				poff[p][k] = {4'(k), 5'(rand_bits(5))}; // one offset in each 32-word block.
				pdat[p][k] = rand_bits(32);
				csr_write(prog_a(poff[p][k]), pdat[p][k]);
			end
		end
		for (int p = 0; p < 2; p++) begin
			csr_write(ctl_a(PAGE), 32'(pg[p]));
			for (int k = 0; k < 16; k++) begin
				expect_read($sformatf("csr_do prog %h", {pg[p], poff[p][k]}),
					prog_a(poff[p][k]), pdat[p][k]);
			end
		end
		report_test("2 memory access", e0);
	endtask

	task automatic test_mesh();
		int e0;
		e0 = errors;
		run_mesh(0);
		wait_done();
		if (!abort) check_drained();
		report_test("3 mesh run", e0);
		if (!abort) begin
			e0 = errors;
			assert (busy_seen) else begin
				$display("busy was not high right after start");
				errors++;
			end
			expect_read("csr_do CTRL", ctl_a(CTRL), 32'h2); // irq set, busy clear.
			check_hex("irq", 64'(irq), 64'h1);
			expect_read("csr_do VERTICES", ctl_a(VERTICES),
				32'((int'(h_last) + 1) * (int'(v_last) + 1)));
			expect_read("csr_do PENDING", ctl_a(PENDING), 32'h0);
			csr_write(ctl_a(CTRL), 32'h0);
			expect_read("csr_do CTRL", ctl_a(CTRL), 32'h0);
			check_hex("irq", 64'(irq), 64'h0);
			expect_read("csr_do VERTICES", ctl_a(VERTICES), 32'h0);
			expect_read("csr_do STRAYS", ctl_a(STRAYS), 32'h0);
			report_test("4 completion and irq", e0);
		end
	endtask

	task automatic test_strays();
		int e0;
		e0 = errors;
		run_mesh(1 + int'(rand_bits(2)) % 3);
		wait_done();
		if (!abort) begin
			check_drained();
			expect_read("csr_do STRAYS", ctl_a(STRAYS), 32'(stray_exp));
		end
		report_test("5 stray opcodes", e0);
	endtask

	initial begin
		sys_rst      = 1'b1;
		csr_a        = '0;
		csr_we       = 1'b0;
		csr_di       = '0;
		dma_ack      = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		abort        = 1'b0;
		repeat (10) @(posedge sys_clk);
		sys_rst <= 1'b0;
		test_readback();
		test_memory();
		test_mesh();
		if (!abort) test_strays();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
